// File: design/sd_cmd_defs.svh
/*
  SD command PHY frame constants
  Bit counts for the command frame, the CRC7 and the two response
  lengths used by the command path in SD mode
*/

`ifndef SD_CMD_DEFS_SVH
`define SD_CMD_DEFS_SVH

// Command bits sent before the CRC, start and transmission bits included
`define SD_CMD_BITS 40

// Width of the CRC7 that trails every command and response
`define SD_CRC_BITS 7

// Response payload bits after the start bit
`define SD_RSP_SHORT_BITS 39
`define SD_RSP_LONG_BITS 135

// Response word, wide enough for a long payload
`define SD_RSP_WORD_BITS 136

`endif

// File: design/sd_cmd_pkg.sv
/*
  SD command PHY types
  Word types for command, response and CRC, and the state
  encodings of the sequencer and the response receiver
*/

`default_nettype none

`include "sd_cmd_defs.svh"

package sd_cmd_pkg;

  typedef logic [`SD_CMD_BITS-1:0] cmd_word_t;

  // Payload right-aligned, upper bits zero
  typedef logic [`SD_RSP_WORD_BITS-1:0] rsp_word_t;

  typedef logic [`SD_CRC_BITS-1:0] crc7_t;

  typedef enum logic [2:0] {
    CMD_IDLE,
    CMD_SEND,
    CMD_TURN,
    CMD_RECEIVE,
    CMD_DONE
  } cmd_state_e;

  typedef enum logic [2:0] {
    RX_WAIT_START,
    RX_PAYLOAD,
    RX_CRC,
    RX_END,
    RX_IDLE
  } rx_state_e;

endpackage

`default_nettype wire

// File: design/sd_crc7.sv
/*
  Serial CRC7 generator
  Polynomial x^7 + x^3 + 1, one bit per enabled cycle,
  cleared to zero on request
*/

`default_nettype none

module sd_crc7
  import sd_cmd_pkg::*;
(
  input  wire   i_sd_clk,
  input  wire   rst,
  input  wire   i_clear,
  input  wire   i_en,
  input  wire   i_bit,
  output crc7_t o_crc
);

  logic feedback;

  // Incoming bit against the MSB about to leave
  assign feedback = i_bit ^ o_crc[6];

  always_ff @(posedge i_sd_clk) begin
    if (rst || i_clear) begin
      o_crc <= '0;
    end else if (i_en) begin
      // Shift left, fold feedback into taps 3 and 0
      o_crc <= {o_crc[5:3], o_crc[2] ^ feedback, o_crc[1:0], feedback};
    end
  end

endmodule

`default_nettype wire

// File: design/sd_cmd_tx.sv
/*
  SD command transmitter
  Drives one frame on the CMD line, MSB first: the command word,
  its CRC7 and a stop bit of 1; idles high while disabled
*/

`default_nettype none

`include "sd_cmd_defs.svh"

module sd_cmd_tx
  import sd_cmd_pkg::*;
(
  input  wire       i_sd_clk,
  input  wire       rst,
  input  wire       i_en,
  input  cmd_word_t i_cmd,
  output logic      o_sd_cmd,
  output logic      o_done
);

  logic [5:0]               bit_cnt;
  cmd_word_t                cmd_sr;
  logic [`SD_CRC_BITS-2:0]  crc_sr;
  crc7_t                    crc;
  logic                     tx_bit;
  logic                     crc_en;

  // Next bit for the line
  // Count 0 takes the MSB straight from the host word
  always_comb begin
    if (bit_cnt == 6'd0) begin
      tx_bit = i_cmd[`SD_CMD_BITS-1];
    end else if (bit_cnt < 6'(`SD_CMD_BITS)) begin
      tx_bit = cmd_sr[`SD_CMD_BITS-1];
    end else if (bit_cnt == 6'(`SD_CMD_BITS)) begin
      tx_bit = crc[`SD_CRC_BITS-1];
    end else begin
      tx_bit = crc_sr[`SD_CRC_BITS-2];
    end
  end

  assign crc_en = i_en && (bit_cnt < 6'(`SD_CMD_BITS));

  sd_crc7 u_crc7 (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_clear  (!i_en),
    .i_en     (crc_en),
    .i_bit    (tx_bit),
    .o_crc    (crc)
  );

  always_ff @(posedge i_sd_clk) begin
    if (rst || !i_en) begin
      bit_cnt  <= '0;
      o_sd_cmd <= 1'b1;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (bit_cnt < 6'(`SD_CMD_BITS + `SD_CRC_BITS)) begin
        o_sd_cmd <= tx_bit;
        bit_cnt  <= bit_cnt + 6'd1;
      end else if (bit_cnt == 6'(`SD_CMD_BITS + `SD_CRC_BITS)) begin
        // Stop bit
        o_sd_cmd <= 1'b1;
        o_done   <= 1'b1;
        bit_cnt  <= bit_cnt + 6'd1;
      end else begin
        // Frame sent, hold the line high until disabled
        o_sd_cmd <= 1'b1;
      end
    end
  end

  // Command and CRC shifters
  always_ff @(posedge i_sd_clk) begin
    if (i_en) begin
      if (bit_cnt == 6'd0) begin
        cmd_sr <= {i_cmd[`SD_CMD_BITS-2:0], 1'b0};
      end else if (bit_cnt < 6'(`SD_CMD_BITS)) begin
        cmd_sr <= {cmd_sr[`SD_CMD_BITS-2:0], 1'b0};
      end
      if (bit_cnt == 6'(`SD_CMD_BITS)) begin
        crc_sr <= crc[`SD_CRC_BITS-2:0];
      end else begin
        crc_sr <= {crc_sr[`SD_CRC_BITS-3:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// File: design/sd_rsp_rx.sv
/*
  SD response receiver
  Hunts for the start bit, captures a short or long payload and
  the trailing CRC7, and flags a CRC mismatch with the done pulse
*/

`default_nettype none

`include "sd_cmd_defs.svh"

module sd_rsp_rx
  import sd_cmd_pkg::*;
(
  input  wire       i_sd_clk,
  input  wire       rst,
  input  wire       i_arm,
  input  wire       i_rsp_long,
  input  wire       i_sd_cmd,
  output rsp_word_t o_rsp,
  output logic      o_done,
  output logic      o_crc_err
);

  rx_state_e  state;
  logic [7:0] bit_cnt;
  logic [7:0] payload_last;
  crc7_t      rx_crc;
  crc7_t      crc_calc;
  logic       start_seen;
  logic       crc_en;

  assign payload_last = i_rsp_long ? 8'(`SD_RSP_LONG_BITS - 1) :
                                     8'(`SD_RSP_SHORT_BITS - 1);

  assign start_seen = (state == RX_WAIT_START) && !i_sd_cmd;

  // Start bit and payload go into the CRC
  assign crc_en = i_arm && (start_seen || (state == RX_PAYLOAD));

  sd_crc7 u_crc7 (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_clear  (!i_arm),
    .i_en     (crc_en),
    .i_bit    (i_sd_cmd),
    .o_crc    (crc_calc)
  );

  always_ff @(posedge i_sd_clk) begin
    if (rst || !i_arm) begin
      state     <= RX_WAIT_START;
      bit_cnt   <= '0;
      o_done    <= 1'b0;
      o_crc_err <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        RX_WAIT_START: begin
          if (!i_sd_cmd) begin
            state   <= RX_PAYLOAD;
            bit_cnt <= '0;
          end
        end
        RX_PAYLOAD: begin
          if (bit_cnt == payload_last) begin
            state   <= RX_CRC;
            bit_cnt <= '0;
          end else begin
            bit_cnt <= bit_cnt + 8'd1;
          end
        end
        RX_CRC: begin
          if (bit_cnt == 8'(`SD_CRC_BITS - 1)) begin
            state <= RX_END;
          end else begin
            bit_cnt <= bit_cnt + 8'd1;
          end
        end
        RX_END: begin
          // End bit on the line, frame complete
          o_done    <= 1'b1;
          o_crc_err <= (rx_crc != crc_calc);
          state     <= RX_IDLE;
        end
        RX_IDLE: begin
          // Wait for the arm to drop
        end
        default: begin
          state <= RX_WAIT_START;
        end
      endcase
    end
  end

  // Payload and received CRC shifters
  always_ff @(posedge i_sd_clk) begin
    if (i_arm) begin
      if (start_seen) begin
        o_rsp <= '0;
      end else if (state == RX_PAYLOAD) begin
        o_rsp <= {o_rsp[`SD_RSP_WORD_BITS-2:0], i_sd_cmd};
      end
      if (state == RX_CRC) begin
        rx_crc <= {rx_crc[`SD_CRC_BITS-2:0], i_sd_cmd};
      end
    end
  end

endmodule

`default_nettype wire

// File: design/sd_cmd_ctrl.sv
/*
  SD command sequencer
  Steps through send, turnaround, receive and done, owns the CMD
  line direction, and aborts to idle whenever the enable drops
*/

`default_nettype none

module sd_cmd_ctrl
  import sd_cmd_pkg::*;
(
  input  wire  i_sd_clk,
  input  wire  rst,
  input  wire  i_cmd_en,
  input  wire  i_tx_done,
  input  wire  i_rx_done,
  input  wire  i_rx_crc_err,
  output logic o_tx_en,
  output logic o_rx_arm,
  output logic o_sd_cmd_dir,
  output logic o_rsp_done,
  output logic o_crc_err
);

  cmd_state_e state;

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      state     <= CMD_IDLE;
      o_crc_err <= 1'b0;
    end else if (!i_cmd_en) begin
      // Out of band abort, also ends a finished transfer
      state     <= CMD_IDLE;
      o_crc_err <= 1'b0;
    end else begin
      case (state)
        CMD_IDLE: begin
          state <= CMD_SEND;
        end
        CMD_SEND: begin
          if (i_tx_done) begin
            state <= CMD_TURN;
          end
        end
        CMD_TURN: begin
          // One cycle with the line released before arming
          state <= CMD_RECEIVE;
        end
        CMD_RECEIVE: begin
          if (i_rx_done) begin
            state     <= CMD_DONE;
            o_crc_err <= i_rx_crc_err;
          end
        end
        CMD_DONE: begin
          // Held until the host drops the enable
        end
        default: begin
          state <= CMD_IDLE;
        end
      endcase
    end
  end

  assign o_tx_en  = (state == CMD_SEND);
  assign o_rx_arm = (state == CMD_RECEIVE);

  // Host owns the line in idle and while sending
  assign o_sd_cmd_dir = (state == CMD_IDLE) || (state == CMD_SEND);

  assign o_rsp_done = (state == CMD_DONE);

endmodule

`default_nettype wire

// File: design/sd_cmd_phy.sv
/*
  SD host command PHY
  Sends a command with CRC7 on the CMD line, turns the line around
  and captures the short or long response with a CRC check
*/

`default_nettype none

module sd_cmd_phy
  import sd_cmd_pkg::*;
(
  input  wire       i_sd_clk,
  input  wire       rst,

  // Host side
  input  wire       i_cmd_en,
  input  cmd_word_t i_cmd,
  input  wire       i_rsp_long,
  output rsp_word_t o_rsp,
  output logic      o_rsp_done,
  output logic      o_crc_err,

  // CMD line
  input  wire       i_sd_cmd,
  output logic      o_sd_cmd,
  output logic      o_sd_cmd_dir
);

  logic tx_en;
  logic tx_done;
  logic rx_arm;
  logic rx_done;
  logic rx_crc_err;

  sd_cmd_ctrl u_ctrl (
    .i_sd_clk     (i_sd_clk),
    .rst          (rst),
    .i_cmd_en     (i_cmd_en),
    .i_tx_done    (tx_done),
    .i_rx_done    (rx_done),
    .i_rx_crc_err (rx_crc_err),
    .o_tx_en      (tx_en),
    .o_rx_arm     (rx_arm),
    .o_sd_cmd_dir (o_sd_cmd_dir),
    .o_rsp_done   (o_rsp_done),
    .o_crc_err    (o_crc_err)
  );

  sd_cmd_tx u_tx (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_en     (tx_en),
    .i_cmd    (i_cmd),
    .o_sd_cmd (o_sd_cmd),
    .o_done   (tx_done)
  );

  sd_rsp_rx u_rx (
    .i_sd_clk   (i_sd_clk),
    .rst        (rst),
    .i_arm      (rx_arm),
    .i_rsp_long (i_rsp_long),
    .i_sd_cmd   (i_sd_cmd),
    .o_rsp      (o_rsp),
    .o_done     (rx_done),
    .o_crc_err  (rx_crc_err)
  );

endmodule

`default_nettype wire

// File: bench/sd_card_model.sv
/*
  Behavioral SD card on the CMD line
  Captures the 48-bit command frame while the host drives the line,
  then answers with a start bit, payload, CRC7 and end bit
*/

`default_nettype none

`include "sd_cmd_defs.svh"

module sd_card_model (
  input  wire                                  i_clk,
  input  wire                                  i_go,
  input  wire                                  i_long,
  input  wire  [`SD_RSP_LONG_BITS-1:0]         i_payload,
  input  wire  [7:0]                           i_delay,
  input  wire                                  i_corrupt,
  input  wire                                  i_cmd_line,
  input  wire                                  i_dir,
  output logic                                 o_line,
  output logic [`SD_CMD_BITS+`SD_CRC_BITS:0]   o_frame,
  output logic                                 o_frame_valid,
  output int                                   o_timeouts
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int FRAME_BITS = `SD_CMD_BITS + `SD_CRC_BITS + 1;
  localparam int WAIT_LIMIT = 2000;

  // One serial CRC7 step, x^7 + x^3 + 1
  function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic din);
    logic fb;
    fb = din ^ crc[6];
    crc7_next = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
  endfunction

  task automatic serve_command();
    logic [6:0] crc;
    logic       dir_ok;
    int         nbits;
    int         waited;
    int         i;
    dir_ok = 1'b1;
    o_frame_valid = 1'b0;
    // First frame bit leaves the host one edge after the enable
    for (i = FRAME_BITS - 1; i >= 0; i--) begin
      @(posedge i_clk);
      @(negedge i_clk);
      o_frame[i] = i_cmd_line;
      if (!i_dir) begin
        dir_ok = 1'b0;
      end
    end
    o_frame_valid = dir_ok;
    waited = 0;
    while (i_dir && waited < WAIT_LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    if (i_dir) begin
      o_timeouts++;
      $display("ERROR at %0t ns: card model saw the host never release the CMD line", $time);
    end else begin
      nbits = i_long ? `SD_RSP_LONG_BITS : `SD_RSP_SHORT_BITS;
      repeat (i_delay) @(posedge i_clk);
      // Start bit counts toward the CRC
      crc = crc7_next(7'd0, 1'b0);
      @(posedge i_clk);
      #2 o_line = 1'b0;
      for (i = nbits - 1; i >= 0; i--) begin
        @(posedge i_clk);
        #2 o_line = i_payload[i];
        crc = crc7_next(crc, i_payload[i]);
      end
      if (i_corrupt) begin
        crc = ~crc;
      end
      for (i = `SD_CRC_BITS - 1; i >= 0; i--) begin
        @(posedge i_clk);
        #2 o_line = crc[i];
      end
      @(posedge i_clk);
      #2 o_line = 1'b1;
    end
  endtask

  initial begin
    int waited;
    o_line        = 1'b1;
    o_frame       = '0;
    o_frame_valid = 1'b0;
    o_timeouts    = 0;
    forever begin
      @(posedge i_clk);
      if (i_go) begin
        serve_command();
        waited = 0;
        while (i_go && waited < WAIT_LIMIT) begin
          @(posedge i_clk);
          waited++;
        end
        if (i_go) begin
          o_timeouts++;
          $display("ERROR at %0t ns: card model waited too long for the host to finish", $time);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_sd_cmd_phy.sv
/*
  Testbench for the SD command PHY
  Runs the cases file through the DUT and a card model, checking
  reset values, the command frame, responses, CRC flag and abort
*/

`default_nettype none

`include "sd_cmd_defs.svh"

module tb_sd_cmd_phy;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CASES  = 14;
  localparam int COLS       = 6;
  localparam int WAIT_LIMIT = 2000;

  logic                                clk;
  logic                                rst;
  logic                                cmd_en;
  logic [`SD_CMD_BITS-1:0]             cmd;
  logic                                rsp_long;
  wire                                 sd_cmd_in;
  logic [`SD_RSP_WORD_BITS-1:0]        rsp;
  logic                                rsp_done;
  logic                                crc_err;
  logic                                sd_cmd_out;
  logic                                sd_cmd_dir;
  logic                                go;
  logic [`SD_RSP_LONG_BITS-1:0]        payload;
  logic [7:0]                          delay;
  logic                                corrupt;
  logic [`SD_CMD_BITS+`SD_CRC_BITS:0]  frame;
  logic                                frame_valid;
  int                                  card_timeouts;
  logic [`SD_CMD_BITS-1:0]             cases [NUM_CASES*COLS];
  logic [15:0]                         lfsr;
  int                                  errors;
  int                                  timeouts;

  always #10 clk = ~clk;

  sd_cmd_phy u_dut (
    .i_sd_clk     (clk),
    .rst          (rst),
    .i_cmd_en     (cmd_en),
    .i_cmd        (cmd),
    .i_rsp_long   (rsp_long),
    .o_rsp        (rsp),
    .o_rsp_done   (rsp_done),
    .o_crc_err    (crc_err),
    .i_sd_cmd     (sd_cmd_in),
    .o_sd_cmd     (sd_cmd_out),
    .o_sd_cmd_dir (sd_cmd_dir)
  );

  sd_card_model u_card (
    .i_clk         (clk),
    .i_go          (go),
    .i_long        (rsp_long),
    .i_payload     (payload),
    .i_delay       (delay),
    .i_corrupt     (corrupt),
    .i_cmd_line    (sd_cmd_out),
    .i_dir         (sd_cmd_dir),
    .o_line        (sd_cmd_in),
    .o_frame       (frame),
    .o_frame_valid (frame_valid),
    .o_timeouts    (card_timeouts)
  );

  // Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    lfsr_next = {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
  endfunction

  // CRC7 of a command word, MSB first
  function automatic logic [6:0] cmd_crc7(input logic [`SD_CMD_BITS-1:0] word);
    logic [6:0] crc;
    logic       fb;
    int         i;
    crc = '0;
    for (i = `SD_CMD_BITS - 1; i >= 0; i--) begin
      fb  = word[i] ^ crc[6];
      crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    cmd_crc7 = crc;
  endfunction

  task automatic check_value(input logic [135:0] actual, input logic [135:0] expected,
                             input string msg);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
               $time, msg, actual, expected);
    end
  endtask

  task automatic run_exchange(input int idx);
    logic [`SD_CMD_BITS-1:0]            word;
    logic                               bad_crc;
    logic [`SD_RSP_LONG_BITS-1:0]       pl;
    logic [`SD_CMD_BITS+`SD_CRC_BITS:0] exp_frame;
    int                                 k;
    int                                 waited;
    word    = cases[idx*COLS];
    bad_crc = cases[idx*COLS+4][0];
    pl      = '0;
    if (cases[idx*COLS+1][0]) begin
      for (k = `SD_RSP_LONG_BITS - 1; k >= 0; k--) begin
        pl[k] = lfsr[0];
        lfsr  = lfsr_next(lfsr);
      end
    end else begin
      pl[`SD_RSP_SHORT_BITS-1:0] = cases[idx*COLS+2][`SD_RSP_SHORT_BITS-1:0];
    end
    exp_frame = {word, cmd_crc7(word), 1'b1};
    @(posedge clk);
    #2;
    cmd      = word;
    rsp_long = cases[idx*COLS+1][0];
    payload  = pl;
    delay    = cases[idx*COLS+3][7:0];
    corrupt  = bad_crc;
    cmd_en   = 1'b1;
    go       = 1'b1;
    // Nothing on the line yet in the cycle of the sampling edge
    repeat (2) @(negedge clk);
    check_value(sd_cmd_out, 1, $sformatf("case %0d idle line before frame", idx));
    repeat (48) @(negedge clk);
    check_value(sd_cmd_dir, 1, $sformatf("case %0d direction in stop bit cycle", idx));
    check_value(sd_cmd_out, 1, $sformatf("case %0d stop bit", idx));
    @(negedge clk);
    check_value(sd_cmd_dir, 0, $sformatf("case %0d direction after stop bit", idx));
    waited = 0;
    while (!rsp_done && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (rsp_done) begin
      check_value(crc_err, bad_crc, $sformatf("case %0d crc error flag", idx));
      check_value(rsp, {1'b0, pl}, $sformatf("case %0d response word", idx));
    end else begin
      timeouts++;
      $display("ERROR at %0t ns: case %0d never raised o_rsp_done", $time, idx);
    end
    check_value(frame_valid, 1, $sformatf("case %0d line direction during frame", idx));
    check_value(frame, exp_frame, $sformatf("case %0d command frame", idx));
    @(posedge clk);
    #2;
    cmd_en = 1'b0;
    go     = 1'b0;
    repeat (2) @(negedge clk);
    check_value(rsp_done, 0, $sformatf("case %0d done after release", idx));
    check_value(crc_err, 0, $sformatf("case %0d crc flag after release", idx));
  endtask

  task automatic run_abort(input int idx);
    int cycles;
    cycles = int'(cases[idx*COLS+5]);
    @(posedge clk);
    #2;
    cmd      = cases[idx*COLS];
    rsp_long = cases[idx*COLS+1][0];
    cmd_en   = 1'b1;
    // Low on the edge that lies the given cycles after the start edge
    repeat (cycles) @(posedge clk);
    #2;
    cmd_en = 1'b0;
    repeat (3) @(negedge clk);
    check_value(sd_cmd_dir, 1, $sformatf("case %0d direction after abort", idx));
    check_value(sd_cmd_out, 1, $sformatf("case %0d line after abort", idx));
    check_value(rsp_done, 0, $sformatf("case %0d done after abort", idx));
  endtask

  initial begin
    int idx;
    clk      = 1'b0;
    rst      = 1'b1;
    cmd_en   = 1'b0;
    cmd      = '0;
    rsp_long = 1'b0;
    go       = 1'b0;
    payload  = '0;
    delay    = '0;
    corrupt  = 1'b0;
    errors   = 0;
    timeouts = 0;
    lfsr     = 16'd7;
    $readmemh("bench/sd_cmd_cases.txt", cases);
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    check_value(sd_cmd_dir, 1, "o_sd_cmd_dir after reset");
    check_value(sd_cmd_out, 1, "o_sd_cmd after reset");
    check_value(rsp_done, 0, "o_rsp_done after reset");
    check_value(crc_err, 0, "o_crc_err after reset");
    for (idx = 0; idx < NUM_CASES; idx++) begin
      if ($isunknown(cases[idx*COLS]) || $isunknown(cases[idx*COLS+COLS-1])) begin
        errors++;
        $display("ERROR: the cases file has no complete line for case %0d", idx);
      end else if (cases[idx*COLS+5] != 0) begin
        run_abort(idx);
      end else begin
        run_exchange(idx);
      end
    end
    timeouts += card_timeouts;
    $display("Errors: %0d  Timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sd_cmd_phy.f
+incdir+design
design/sd_cmd_pkg.sv
design/sd_crc7.sv
design/sd_cmd_tx.sv
design/sd_rsp_rx.sv
design/sd_cmd_ctrl.sv
design/sd_cmd_phy.sv
bench/sd_card_model.sv
bench/tb_sd_cmd_phy.sv

// File: Bender.yml
package:
  name: sd_cmd_phy

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/sd_cmd_pkg.sv
      - design/sd_crc7.sv
      - design/sd_cmd_tx.sv
      - design/sd_rsp_rx.sv
      - design/sd_cmd_ctrl.sv
      - design/sd_cmd_phy.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/sd_card_model.sv
      - bench/tb_sd_cmd_phy.sv

// File: bench/sd_cmd_cases.txt
// cmd_word long short_payload delay corrupt abort_cycle, all in hex
// abort_cycle 0 runs the full exchange, else cycles after the enable is sampled
4000000000 0 0000000900 0 0 0
48000001AA 0 08000001AA 1 0 0
7700000000 0 3700000120 3 0 0
6940FF8000 0 3F80FF8000 7 0 0
4200000000 1 0000000000 2 0 0
5100001000 0 1100000900 0 1 0
4912340000 1 0000000000 5 0 0
4D12340000 0 0000000000 0 0 14
4D12340000 0 0D00000900 4 0 0
4912340000 1 0000000000 0 1 0
4800000155 0 0000000000 0 0 46
48000001AA 0 08000001AA C 0 0
7700000000 0 0000000000 0 0 1
5000000200 0 1000000900 19 0 0
